//--- can_desc_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_dma_settings.svh"

module can_desc_fetch
    import can_dma_pkg::*;
(
    input  wire          bs,
    input  wire          rst_n,
    input  wire          chain_start,
    input  wire   [31:0] chain_base,
    input  wire          bus_grant,
    input  wire   [31:0] bus_rdata,
    input  wire          tx_active,
    output bus_req_t     bus_req,
    output frame_words_t desc_words,
    output logic         desc_launch,
    output logic         chain_active
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_DATA,
        ST_LAUNCH,
        ST_WAIT_HI,
        ST_WAIT_LO,
        ST_WR_REQ,
        ST_LINK
    } state_t;

    state_t      state;
    logic [2:0]  word_idx;
    logic [2:0]  next_idx;
    logic [31:0] base;
    logic [31:0] cpl_addr;
    logic [31:0] cpl_data;
    logic [31:0] link;

    assign next_idx = word_idx + 3'd1;

    // launch only into an idle transmitter
    assign desc_launch = (state == ST_LAUNCH) && !tx_active;

    always_ff @(posedge bs or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            word_idx     <= 3'd0;
            bus_req      <= '0;
            chain_active <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (chain_start) begin
                        chain_active <= 1'b1;
                        word_idx     <= 3'd0;
                        bus_req      <= '{busreq: 1'b1, write: 1'b0,
                                          addr: chain_base, wdata: 32'd0};
                        state        <= ST_RD_REQ;
                    end
                end
                ST_RD_REQ: begin
                    if (bus_grant) begin
                        bus_req.busreq <= 1'b0;
                        state          <= ST_RD_DATA;
                    end
                end
                // data word is sampled on this edge
                ST_RD_DATA: begin
                    if (word_idx == 3'(`CAN_DESC_WORDS - 1)) begin
                        state <= ST_LAUNCH;
                    end else begin
                        word_idx       <= next_idx;
                        bus_req.busreq <= 1'b1;
                        bus_req.addr   <= base + 32'(next_idx) * `CAN_WORD_BYTES;
                        state          <= ST_RD_REQ;
                    end
                end
                ST_LAUNCH: begin
                    if (!tx_active) begin
                        state <= ST_WAIT_HI;
                    end
                end
                ST_WAIT_HI: begin
                    if (tx_active) begin
                        state <= ST_WAIT_LO;
                    end
                end
                // post the completion word once the transmitter is done
                ST_WAIT_LO: begin
                    if (!tx_active) begin
                        bus_req <= '{busreq: 1'b1, write: 1'b1,
                                     addr: cpl_addr, wdata: cpl_data};
                        state   <= ST_WR_REQ;
                    end
                end
                ST_WR_REQ: begin
                    if (bus_grant) begin
                        bus_req.busreq <= 1'b0;
                        bus_req.write  <= 1'b0;
                        state          <= ST_LINK;
                    end
                end
                ST_LINK: begin
                    if (link == 32'd0) begin
                        chain_active <= 1'b0;
                        state        <= ST_IDLE;
                    end else begin
                        word_idx <= 3'd0;
                        bus_req  <= '{busreq: 1'b1, write: 1'b0, addr: link, wdata: 32'd0};
                        state    <= ST_RD_REQ;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // descriptor payload
    always_ff @(posedge bs) begin
        if (state == ST_IDLE && chain_start) begin
            base <= chain_base;
        end
        if (state == ST_LINK) begin
            base <= link;
        end
        if (state == ST_RD_DATA) begin
            case (word_idx)
                `CAN_DESC_DH:    desc_words.dh  <= bus_rdata;
                `CAN_DESC_DL:    desc_words.dl  <= bus_rdata;
                `CAN_DESC_CMD:   desc_words.cmd <= bus_rdata;
                `CAN_DESC_ID:    desc_words.id  <= bus_rdata;
                `CAN_DESC_CADDR: cpl_addr       <= bus_rdata;
                `CAN_DESC_CDATA: cpl_data       <= bus_rdata;
                default:         link           <= bus_rdata;
            endcase
        end
    end

    // request held unchanged until the grant edge
    a_req_hold: assert property (@(posedge bs) disable iff (!rst_n)
        bus_req.busreq && !bus_grant |=> $stable(bus_req))
        else $error("bus request changed before grant");

    // launcher must take the frame and go active next cycle
    a_launch_idle: assert property (@(posedge bs) disable iff (!rst_n)
        desc_launch |=> tx_active)
        else $error("descriptor launch not accepted");

endmodule

`default_nettype wire

//--- can_dma_pkg.sv
`default_nettype none

package can_dma_pkg;

`include "can_dma_settings.svh"

    // raw frame words as the host or a descriptor supplies them
    typedef struct packed {
        logic [31:0] dh;
        logic [31:0] dl;
        logic [31:0] cmd;
        logic [31:0] id;
    } frame_words_t;

    // decoded frame handed to the transmitter
    typedef struct packed {
        logic [63:0]          data;
        logic [`CAN_ID_W-1:0] id;
        logic [7:0]           quanta_div;
        logic [5:0]           prop_quanta;
        logic [5:0]           seg1_quanta;
        logic [3:0]           datalen;
        logic                 format;
        logic [1:0]           frame_type;
    } can_frame_t;

    // memory bus master request
    typedef struct packed {
        logic        busreq;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

endpackage

`default_nettype wire

//--- can_dma_settings.svh
`ifndef CAN_DMA_SETTINGS_SVH
`define CAN_DMA_SETTINGS_SVH

// host register map as 16-bit offsets
`define CAN_REG_DH      16'hFF00
`define CAN_REG_DL      16'hFF04
`define CAN_REG_CMD     16'hFF08
`define CAN_REG_ID      16'hFF0C
`define CAN_REG_LAUNCH  16'hFF10
`define CAN_REG_CHAIN   16'hFF14
`define CAN_REG_ACTIVE  16'hFF18

// descriptor layout in memory with one 32-bit word per slot
`define CAN_DESC_WORDS  7
`define CAN_WORD_BYTES  4
`define CAN_DESC_DH     3'd0
`define CAN_DESC_DL     3'd1
`define CAN_DESC_CMD    3'd2
`define CAN_DESC_ID     3'd3
`define CAN_DESC_CADDR  3'd4
`define CAN_DESC_CDATA  3'd5

// identifier sits in ID[31:3]
`define CAN_ID_W        29
`endif

//--- can_dma_top.f
+incdir+.
can_dma_pkg.sv
can_reg_slave.sv
can_desc_fetch.sv
can_launch.sv
can_dma_top.sv
tb_can_dma.sv

//--- can_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module can_dma_top
    import can_dma_pkg::*;
(
    input  wire         bs,
    input  wire         rst_n,
    // host register port
    input  wire         reg_wr,
    input  wire         reg_rd,
    input  wire  [15:0] reg_addr,
    input  wire  [31:0] reg_wdata,
    output logic [31:0] reg_rdata,
    // memory bus master
    output bus_req_t    bus_req,
    input  wire         bus_grant,
    input  wire  [31:0] bus_rdata,
    // transmitter
    output logic        can_start,
    output can_frame_t  can_frame,
    input  wire         can_busy
);

    frame_words_t reg_words;
    frame_words_t desc_words;
    logic         reg_launch;
    logic         desc_launch;
    logic         chain_start;
    logic  [31:0] chain_base;
    logic         tx_active;
    logic         chain_active;

    can_reg_slave u_reg_slave (
        .bs           (bs),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .tx_active    (tx_active),
        .chain_active (chain_active),
        .reg_rdata    (reg_rdata),
        .reg_words    (reg_words),
        .reg_launch   (reg_launch),
        .chain_start  (chain_start),
        .chain_base   (chain_base)
    );

    can_desc_fetch u_desc_fetch (
        .bs           (bs),
        .rst_n        (rst_n),
        .chain_start  (chain_start),
        .chain_base   (chain_base),
        .bus_grant    (bus_grant),
        .bus_rdata    (bus_rdata),
        .tx_active    (tx_active),
        .bus_req      (bus_req),
        .desc_words   (desc_words),
        .desc_launch  (desc_launch),
        .chain_active (chain_active)
    );

    can_launch u_launch (
        .bs          (bs),
        .rst_n       (rst_n),
        .reg_words   (reg_words),
        .reg_launch  (reg_launch),
        .desc_words  (desc_words),
        .desc_launch (desc_launch),
        .can_busy    (can_busy),
        .can_start   (can_start),
        .can_frame   (can_frame),
        .tx_active   (tx_active)
    );

endmodule

`default_nettype wire

//--- can_launch.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_dma_settings.svh"

module can_launch
    import can_dma_pkg::*;
(
    input  wire          bs,
    input  wire          rst_n,
    input  wire          frame_words_t reg_words,
    input  wire          reg_launch,
    input  wire          frame_words_t desc_words,
    input  wire          desc_launch,
    input  wire          can_busy,
    output logic         can_start,
    output can_frame_t   can_frame,
    output logic         tx_active
);

    frame_words_t pend_words;
    frame_words_t launch_words;
    logic         pend_valid;
    logic         launch_now;
    logic         park_desc;

    function automatic can_frame_t decode(input frame_words_t w);
        can_frame_t f;
        f.data        = {w.dh, w.dl};
        f.id          = w.id[31 -: `CAN_ID_W];
        f.quanta_div  = w.cmd[31:24];
        f.prop_quanta = w.cmd[23:18];
        f.seg1_quanta = w.cmd[17:12];
        f.datalen     = w.cmd[11:8];
        f.format      = w.cmd[7];
        f.frame_type  = w.cmd[6:5];
        return f;
    endfunction

    // held descriptor first, then register, then descriptor
    always_comb begin
        launch_now   = 1'b0;
        launch_words = reg_words;
        if (!tx_active) begin
            if (pend_valid) begin
                launch_now   = 1'b1;
                launch_words = pend_words;
            end else if (reg_launch) begin
                launch_now   = 1'b1;
            end else if (desc_launch) begin
                launch_now   = 1'b1;
                launch_words = desc_words;
            end
        end
    end

    // descriptor loses a same-cycle race to the register path
    assign park_desc = !tx_active && !pend_valid && reg_launch && desc_launch;

    always_ff @(posedge bs or negedge rst_n) begin
        if (!rst_n) begin
            can_start  <= 1'b0;
            tx_active  <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            can_start <= launch_now;
            if (launch_now) begin
                tx_active <= 1'b1;
            end else if (tx_active && !can_start && !can_busy) begin
                tx_active <= 1'b0;
            end
            if (park_desc) begin
                pend_valid <= 1'b1;
            end else if (!tx_active && pend_valid) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge bs) begin
        if (park_desc) begin
            pend_words <= desc_words;
        end
        if (launch_now) begin
            can_frame <= decode(launch_words);
        end
    end

    a_start_pulse: assert property (@(posedge bs) disable iff (!rst_n)
        can_start |=> !can_start)
        else $error("can_start held for two cycles");

endmodule

`default_nettype wire

//--- can_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_dma_settings.svh"

module can_reg_slave
    import can_dma_pkg::*;
(
    input  wire          bs,
    input  wire          rst_n,
    input  wire          reg_wr,
    input  wire          reg_rd,
    input  wire   [15:0] reg_addr,
    input  wire   [31:0] reg_wdata,
    input  wire          tx_active,
    input  wire          chain_active,
    output logic  [31:0] reg_rdata,
    output frame_words_t reg_words,
    output logic         reg_launch,
    output logic         chain_start,
    output logic  [31:0] chain_base
);

    logic wr_launch;
    logic wr_chain;

    assign wr_launch = reg_wr && (reg_addr == `CAN_REG_LAUNCH);
    assign wr_chain  = reg_wr && (reg_addr == `CAN_REG_CHAIN);

    // frame words and chain base, written by offset
    always_ff @(posedge bs) begin
        if (reg_wr) begin
            case (reg_addr)
                `CAN_REG_DH:    reg_words.dh  <= reg_wdata;
                `CAN_REG_DL:    reg_words.dl  <= reg_wdata;
                `CAN_REG_CMD:   reg_words.cmd <= reg_wdata;
                `CAN_REG_ID:    reg_words.id  <= reg_wdata;
                `CAN_REG_CHAIN: chain_base    <= reg_wdata;
                default: ;
            endcase
        end
    end

    // strobes come one cycle after the write,
    // so chain_base already holds the new value
    always_ff @(posedge bs or negedge rst_n) begin
        if (!rst_n) begin
            reg_launch  <= 1'b0;
            chain_start <= 1'b0;
        end else begin
            reg_launch  <= wr_launch;
            chain_start <= wr_chain;
        end
    end

    // readback mux
    always_comb begin
        reg_rdata = 32'd0;
        if (reg_rd) begin
            case (reg_addr)
                `CAN_REG_DH:     reg_rdata = reg_words.dh;
                `CAN_REG_DL:     reg_rdata = reg_words.dl;
                `CAN_REG_CMD:    reg_rdata = reg_words.cmd;
                `CAN_REG_ID:     reg_rdata = reg_words.id;
                `CAN_REG_LAUNCH: reg_rdata = {31'd0, tx_active};
                `CAN_REG_CHAIN:  reg_rdata = chain_base;
                `CAN_REG_ACTIVE: reg_rdata = {31'd0, chain_active};
                default:         reg_rdata = 32'd0;
            endcase
        end
    end

    // host never issues a read and a write in the same cycle
    a_no_rd_wr: assert property (@(posedge bs) disable iff (!rst_n) !(reg_wr && reg_rd))
        else $error("reg_wr and reg_rd high together");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench, then scan the log for the fail message
rm -f sim.log
verilator --binary --timing --assert --top-module tb_can_dma -f can_dma_top.f \
    && ./obj_dir/Vtb_can_dma > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- tb_can_dma.sv
`timescale 1ns/1ps
`default_nettype none

`include "can_dma_settings.svh"

module tb_can_dma
    import can_dma_pkg::*;
();

    logic        bs = 1'b0;
    logic        rst_n;
    logic        reg_wr;
    logic        reg_rd;
    logic [15:0] reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    bus_req_t    bus_req;
    logic        bus_grant = 1'b0;
    logic [31:0] bus_rdata = 32'd0;
    logic        can_start;
    can_frame_t  can_frame;
    logic        can_busy = 1'b0;

    // descriptors written by the test and completions written over the bus
    logic [31:0] desc_mem [logic [31:0]];
    logic [31:0] cpl_mem [logic [31:0]];
    logic [31:0] stim_rng = 32'h393a_dd2c;
    logic [31:0] grant_rng = 32'h393a_dd2c ^ 32'h0000_5a5a;
    logic [31:0] busy_rng = 32'h393a_dd2c ^ 32'h00a5_0000;
    int          grant_wait = 0;
    int          busy_left = 0;
    logic [31:0] watch_addr = 32'hffff_ffff;
    logic        watch_hit = 1'b0;
    can_frame_t  got_q[$];
    can_frame_t  exp_q[$];
    logic [31:0] cpl_addr_q[$];
    logic [31:0] cpl_data_q[$];
    logic [31:0] wr_words[$];
    logic [15:0] frame_offs [0:3] = '{`CAN_REG_DH, `CAN_REG_DL, `CAN_REG_CMD, `CAN_REG_ID};
    logic [31:0] cpl_next = 32'h0200_0000;
    int          seen = 0;
    int          errors = 0;
    int          errors_mark = 0;
    int          checks = 0;
    int          test_no = 0;

    can_dma_top UUT (
        .bs        (bs),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .bus_req   (bus_req),
        .bus_grant (bus_grant),
        .bus_rdata (bus_rdata),
        .can_start (can_start),
        .can_frame (can_frame),
        .can_busy  (can_busy)
    );

    always #50 bs = ~bs;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // frame fields in bit order are DH, DL, ID[31:3] and CMD[31:5]
    function automatic can_frame_t expect_frame(input logic [31:0] dh, input logic [31:0] dl,
                                                input logic [31:0] cmd, input logic [31:0] id);
        can_frame_t f;
        f = {dh, dl, id[31:3], cmd[31:5]};
        return f;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (cpl_mem.exists(addr)) begin
            return cpl_mem[addr];
        end
        if (desc_mem.exists(addr)) begin
            return desc_mem[addr];
        end
        // unwritten locations
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    // memory model with random grant latency and read data one cycle after the grant edge
    always @(posedge bs) begin
        if (bus_req.busreq && bus_grant) begin
            if (bus_req.write) begin
                cpl_mem[bus_req.addr] = bus_req.wdata;
            end else begin
                bus_rdata <= mem_word(bus_req.addr);
            end
            bus_grant <= 1'b0;
            grant_rng = xorshift32(grant_rng);
            grant_wait = int'(grant_rng % 32'd6);
        end else if (bus_req.busreq) begin
            if (grant_wait == 0) begin
                bus_grant <= 1'b1;
                // the transfer happens on the next edge
                if (!bus_req.write && bus_req.addr == watch_addr) begin
                    watch_hit = 1'b1;
                end
            end else begin
                grant_wait = grant_wait - 1;
            end
        end
    end

    // transmitter model stays busy for 2 to 12 cycles after start
    always @(posedge bs) begin
        if (can_start) begin
            got_q.push_back(can_frame);
            busy_rng = xorshift32(busy_rng);
            busy_left = 2 + int'(busy_rng % 32'd11);
            can_busy <= 1'b1;
        end else if (busy_left > 0) begin
            busy_left = busy_left - 1;
            if (busy_left == 0) begin
                can_busy <= 1'b0;
            end
        end
    end

    task automatic draw_random(output logic [31:0] v);
        stim_rng = xorshift32(stim_rng);
        v = stim_rng;
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_frame(input string name, input can_frame_t got, input can_frame_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge bs);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge bs);
        reg_wr    <= 1'b0;
    endtask

    // read data is combinational and taken mid-cycle
    task automatic reg_read(input logic [15:0] addr, output logic [31:0] data);
        @(posedge bs);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(negedge bs);
        data = reg_rdata;
        @(posedge bs);
        reg_rd   <= 1'b0;
    endtask

    task automatic wait_starts(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (got_q.size() < target && n < limit) begin
            @(negedge bs);
            n++;
        end
        check_true(got_q.size() >= target, what);
    endtask

    // returns in the cycle where the last descriptor word is granted
    task automatic wait_last_word(input int limit);
        int n;
        n = 0;
        while (!watch_hit && n < limit) begin
            @(negedge bs);
            n++;
        end
        check_true(watch_hit, "timeout waiting for the last descriptor word");
    endtask

    task automatic wait_bit_clear(input logic [15:0] addr, input int limit, input string what);
        logic [31:0] v;
        int n;
        v = 32'd1;
        n = 0;
        while (v[0] && n < limit) begin
            reg_read(addr, v);
            n++;
        end
        check_true(!v[0], what);
    endtask

    task automatic write_frame_regs();
        logic [31:0] w;
        wr_words.delete();
        for (int i = 0; i < 4; i++) begin
            draw_random(w);
            wr_words.push_back(w);
            reg_write(frame_offs[i], w);
        end
    endtask

    task automatic push_reg_frame();
        exp_q.push_back(expect_frame(wr_words[0], wr_words[1], wr_words[2], wr_words[3]));
    endtask

    // DH, DL, CMD, ID, completion address, completion data, link
    task automatic place_descriptor(input logic [31:0] addr, input logic [31:0] link);
        logic [31:0] w[$];
        logic [31:0] v;
        for (int i = 0; i < 4; i++) begin
            draw_random(v);
            w.push_back(v);
        end
        w.push_back(cpl_next);
        draw_random(v);
        w.push_back(v);
        w.push_back(link);
        cpl_next = cpl_next + 32'd4;
        for (int i = 0; i < `CAN_DESC_WORDS; i++) begin
            desc_mem[addr + 32'(i * `CAN_WORD_BYTES)] = w[i];
        end
        exp_q.push_back(expect_frame(w[0], w[1], w[2], w[3]));
        cpl_addr_q.push_back(w[4]);
        cpl_data_q.push_back(w[5]);
    endtask

    task automatic check_frames_in_order();
        check_true(got_q.size() - seen == exp_q.size(), "wrong number of frames started");
        for (int i = 0; i < exp_q.size() && seen + i < got_q.size(); i++) begin
            check_frame("can_frame", got_q[seen + i], exp_q[i]);
        end
        seen = got_q.size();
        exp_q.delete();
    endtask

    task automatic check_completions();
        for (int i = 0; i < cpl_addr_q.size(); i++) begin
            check_true(cpl_mem.exists(cpl_addr_q[i]), "completion word was never written");
            check_word("completion word", mem_word(cpl_addr_q[i]), cpl_data_q[i]);
        end
        cpl_addr_q.delete();
        cpl_data_q.delete();
    endtask

    task automatic finish_test(input string name);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, errors - errors_mark);
        errors_mark = errors;
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] bases[$];
        int          s0;
        logic        ok;

        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = 16'd0;
        reg_wdata = 32'd0;
        repeat (8) @(posedge bs);
        rst_n <= 1'b1;

        // readback with a one-descriptor chain behind the random base
        reg_read(`CAN_REG_LAUNCH, v);
        check_word("busy after reset", v, 32'd0);
        write_frame_regs();
        for (int i = 0; i < 4; i++) begin
            reg_read(frame_offs[i], v);
            check_word("frame word", v, wr_words[i]);
        end
        draw_random(v);
        bases.push_back(32'h0008_0000 + (v & 32'h0000_0ff0));
        place_descriptor(bases[0], 32'd0);
        reg_write(`CAN_REG_CHAIN, bases[0]);
        reg_read(`CAN_REG_CHAIN, v);
        check_word("chain base", v, bases[0]);
        wait_bit_clear(`CAN_REG_ACTIVE, 500, "timeout waiting for the chain to finish");
        check_frames_in_order();
        check_completions();
        finish_test("register readback");

        write_frame_regs();
        push_reg_frame();
        s0 = got_q.size();
        reg_write(`CAN_REG_LAUNCH, 32'd1);
        wait_starts(s0 + 1, 20, "timeout waiting for can_start");
        reg_read(`CAN_REG_LAUNCH, v);
        check_word("busy while sending", v, 32'd1);
        wait_bit_clear(`CAN_REG_LAUNCH, 100, "timeout waiting for the transmitter to go idle");
        check_frames_in_order();
        finish_test("register launch");

        // second launch lands while the first frame is still busy
        write_frame_regs();
        push_reg_frame();
        s0 = got_q.size();
        reg_write(`CAN_REG_LAUNCH, 32'd1);
        wait_starts(s0 + 1, 20, "timeout waiting for can_start");
        reg_write(`CAN_REG_LAUNCH, 32'd1);
        wait_bit_clear(`CAN_REG_LAUNCH, 100, "timeout waiting for the transmitter to go idle");
        repeat (20) @(negedge bs);
        check_frames_in_order();
        finish_test("launch while busy");

        bases.delete();
        for (int i = 0; i < 3; i++) begin
            draw_random(v);
            bases.push_back(32'h0010_0000 * (i + 1) + (v & 32'h0000_0ff0));
        end
        place_descriptor(bases[0], bases[1]);
        place_descriptor(bases[1], bases[2]);
        place_descriptor(bases[2], 32'd0);
        s0 = got_q.size();
        reg_write(`CAN_REG_CHAIN, bases[0]);
        wait_starts(s0 + 3, 3000, "timeout waiting for three descriptor frames");
        wait_bit_clear(`CAN_REG_ACTIVE, 1000, "timeout waiting for the chain to finish");
        reg_read(`CAN_REG_ACTIVE, v);
        check_word("chain active", v, 32'd0);
        check_frames_in_order();
        check_completions();
        finish_test("descriptor chain");

        // register launch in the same cycle as the descriptor launch
        draw_random(v);
        bases.delete();
        bases.push_back(32'h0050_0000 + (v & 32'h0000_0ff0));
        place_descriptor(bases[0], 32'd0);
        write_frame_regs();
        push_reg_frame();
        s0 = got_q.size();
        watch_addr = bases[0] + 32'((`CAN_DESC_WORDS - 1) * `CAN_WORD_BYTES);
        reg_write(`CAN_REG_CHAIN, bases[0]);
        wait_last_word(1000);
        reg_write(`CAN_REG_LAUNCH, 32'd1);
        wait_starts(s0 + 2, 1000, "timeout waiting for both frames");
        wait_bit_clear(`CAN_REG_ACTIVE, 500, "timeout waiting for the chain to finish");
        wait_bit_clear(`CAN_REG_LAUNCH, 100, "timeout waiting for the transmitter to go idle");
        check_true(got_q.size() - s0 == 2, "frames lost or sent twice");
        ok = got_q.size() - s0 == 2
            && ((got_q[s0] === exp_q[0] && got_q[s0 + 1] === exp_q[1])
            || (got_q[s0] === exp_q[1] && got_q[s0 + 1] === exp_q[0]));
        check_true(ok, "frames do not match the register and descriptor words");
        seen = got_q.size();
        exp_q.delete();
        check_completions();
        finish_test("register launch during chain");

        $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
